// File: hdl/sbq_cfg.svh
`ifndef SBQ_CFG_SVH
`define SBQ_CFG_SVH

// queue count and entry geometry
`define SBQ_NUM_QUEUES 2
`define SBQ_ENTRY_BYTES 64

// register map constants
`define SBQ_ID_VERSION 32'h5b51_0100
`define SBQ_QUEUE_BASE 32'h0000_0100
`define SBQ_REG_STRIDE 32'h0000_0020

`define SBQ_RESET_CAPACITY 32'd2
`define SBQ_UNMAPPED_VALUE 32'hffff_ffff

`endif

// File: hdl/sbq_pkg.sv
package sbq_pkg;

    typedef struct packed {
        logic [31:0] addr;
    } axil_aw_t;

    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  strb;
    } axil_w_t;

    typedef struct packed {
        logic [1:0] resp;
    } axil_b_t;

    typedef struct packed {
        logic [31:0] addr;
    } axil_ar_t;

    typedef struct packed {
        logic [31:0] data;
        logic [1:0]  resp;
    } axil_r_t;

    typedef struct packed {
        logic [63:0] base_addr;
        logic [31:0] capacity;
        logic        enable;
    } queue_cfg_t;

    // offsets inside one queue window
    typedef enum logic [4:0] {
        BASE_LO  = 5'h00,
        BASE_HI  = 5'h04,
        CAPACITY = 5'h08,
        ENABLE   = 5'h0c,
        RESET    = 5'h10,
        STATUS   = 5'h14
    } reg_offset_e;

    // global registers sit below the first window, their offsets overlap the window offsets
    localparam logic [31:0] ID_VERSION = 32'h000;
    localparam logic [31:0] CAPABILITY = 32'h004;

    typedef enum logic [1:0] {
        IDLE,
        WRITE_RESP,
        READ_RESP
    } bridge_state_e;

    localparam logic [1:0] resp_okay = 2'b00;

endpackage

// File: hdl/axil_register.sv
`timescale 1ns/100ps

module axil_register (
    input  logic              clk,
    input  logic              arst_n,

    input  sbq_pkg::axil_aw_t s_aw,
    input  logic              s_aw_valid,
    output logic              s_aw_ready,
    input  sbq_pkg::axil_w_t  s_w,
    input  logic              s_w_valid,
    output logic              s_w_ready,
    output sbq_pkg::axil_b_t  s_b,
    output logic              s_b_valid,
    input  logic              s_b_ready,
    input  sbq_pkg::axil_ar_t s_ar,
    input  logic              s_ar_valid,
    output logic              s_ar_ready,
    output sbq_pkg::axil_r_t  s_r,
    output logic              s_r_valid,
    input  logic              s_r_ready,

    output sbq_pkg::axil_aw_t m_aw,
    output logic              m_aw_valid,
    input  logic              m_aw_ready,
    output sbq_pkg::axil_w_t  m_w,
    output logic              m_w_valid,
    input  logic              m_w_ready,
    input  sbq_pkg::axil_b_t  m_b,
    input  logic              m_b_valid,
    output logic              m_b_ready,
    output sbq_pkg::axil_ar_t m_ar,
    output logic              m_ar_valid,
    input  logic              m_ar_ready,
    input  sbq_pkg::axil_r_t  m_r,
    input  logic              m_r_valid,
    output logic              m_r_ready
);

    // channel order in the vectors below is aw, w, b, ar, r
    logic [4:0] in_valid;
    logic [4:0] in_ready;
    logic [4:0] out_ready;
    logic [4:0] full;
    logic [4:0] take;
    logic       live;      // keeps every ready low in the first cycle out of reset

    assign in_valid  = {s_aw_valid, s_w_valid, m_b_valid, s_ar_valid, m_r_valid};
    assign out_ready = {m_aw_ready, m_w_ready, s_b_ready, m_ar_ready, s_r_ready};

    // a full stage only takes a new beat while its old one leaves
    assign in_ready = {5{live}} & (~full | out_ready);
    assign take     = in_valid & in_ready;

    assign {s_aw_ready, s_w_ready, m_b_ready, s_ar_ready, m_r_ready} = in_ready;
    assign {m_aw_valid, m_w_valid, s_b_valid, m_ar_valid, s_r_valid} = full;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            live <= 1'b0;
            full <= '0;
        end else begin
            live <= 1'b1;
            full <= (in_ready & in_valid) | (~in_ready & full);
        end
    end

    always_ff @(posedge clk) begin
        if (take[4]) m_aw <= s_aw;
        if (take[3]) m_w  <= s_w;
        if (take[2]) s_b  <= m_b;   // responses travel back toward the host
        if (take[1]) m_ar <= s_ar;
        if (take[0]) s_r  <= m_r;
    end

endmodule

// File: hdl/axil_reg_if.sv
`timescale 1ns/100ps

module axil_reg_if (
    input  logic              clk,
    input  logic              arst_n,

    input  sbq_pkg::axil_aw_t aw,
    input  logic              aw_valid,
    output logic              aw_ready,
    input  sbq_pkg::axil_w_t  w,
    input  logic              w_valid,
    output logic              w_ready,
    output sbq_pkg::axil_b_t  b,
    output logic              b_valid,
    input  logic              b_ready,
    input  sbq_pkg::axil_ar_t ar,
    input  logic              ar_valid,
    output logic              ar_ready,
    output sbq_pkg::axil_r_t  r,
    output logic              r_valid,
    input  logic              r_ready,

    output logic              wr_en,
    output logic [31:0]       wr_addr,
    output logic [31:0]       wr_data,
    output logic [3:0]        wr_strb,
    output logic              rd_en,
    output logic [31:0]       rd_addr,
    input  logic [31:0]       rd_data
);

    sbq_pkg::bridge_state_e state;
    logic                   write_pair;
    logic [31:0]            rdata_q;

    assign write_pair = aw_valid && w_valid;

    // aw and w are always taken together, a read waits while a write pair is offered
    assign aw_ready = (state == sbq_pkg::IDLE) && write_pair;
    assign w_ready  = aw_ready;
    assign ar_ready = (state == sbq_pkg::IDLE) && !write_pair && ar_valid;

    assign b_valid = (state == sbq_pkg::WRITE_RESP);
    assign b.resp  = sbq_pkg::resp_okay;
    assign r.data  = rdata_q;
    assign r.resp  = sbq_pkg::resp_okay;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= sbq_pkg::IDLE;
            wr_en   <= 1'b0;
            rd_en   <= 1'b0;
            r_valid <= 1'b0;
        end else begin
            wr_en <= aw_ready;
            rd_en <= ar_ready;
            if (rd_en) begin
                r_valid <= 1'b1;    // read data lands in rdata_q on this same edge
            end else if (r_ready) begin
                r_valid <= 1'b0;
            end
            case (state)
                sbq_pkg::IDLE: begin
                    if (aw_ready) begin
                        state <= sbq_pkg::WRITE_RESP;
                    end else if (ar_ready) begin
                        state <= sbq_pkg::READ_RESP;
                    end
                end
                sbq_pkg::WRITE_RESP: begin
                    if (b_ready) state <= sbq_pkg::IDLE;
                end
                sbq_pkg::READ_RESP: begin
                    if (r_valid && r_ready) state <= sbq_pkg::IDLE;
                end
                default: state <= sbq_pkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (aw_ready) begin
            wr_addr <= aw.addr;
            wr_data <= w.data;
            wr_strb <= w.strb;
        end
        if (ar_ready) rd_addr <= ar.addr;
        if (rd_en) rdata_q <= rd_data;
    end

endmodule

// File: hdl/config_registers.sv
`timescale 1ns/100ps
`include "sbq_cfg.svh"

module config_registers (
    input  logic                                       clk,
    input  logic                                       arst_n,
    input  logic                                       wr_en,
    input  logic [31:0]                                wr_addr,
    input  logic [31:0]                                wr_data,
    input  logic [3:0]                                 wr_strb,
    input  logic                                       rd_en,
    input  logic [31:0]                                rd_addr,
    output logic [31:0]                                rd_data,
    input  logic [`SBQ_NUM_QUEUES-1:0]                 status_idle,
    output sbq_pkg::queue_cfg_t [`SBQ_NUM_QUEUES-1:0] queue_cfg,
    output logic [`SBQ_NUM_QUEUES-1:0]                 q_reset
);

    localparam sbq_pkg::queue_cfg_t cfg_default = '{
        base_addr: 64'd0,
        capacity:  `SBQ_RESET_CAPACITY,
        enable:    1'b0
    };

    // offset of addr inside the window of queue idx, huge when addr lies below it
    function automatic logic [31:0] window_offset(input logic [31:0] addr, input int idx);
        return addr - (`SBQ_QUEUE_BASE + 32'(idx) * `SBQ_REG_STRIDE);
    endfunction

    // keeps the bytes of old_val whose strobe is low
    function automatic logic [31:0] strobed(input logic [31:0] old_val);
        logic [31:0] res;
        for (int b = 0; b < 4; b++) begin
            res[8*b +: 8] = wr_strb[b] ? wr_data[8*b +: 8] : old_val[8*b +: 8];
        end
        return res;
    endfunction

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `SBQ_NUM_QUEUES; i++) begin
                queue_cfg[i] <= cfg_default;
            end
            q_reset <= '0;
        end else begin
            q_reset <= '0;
            for (int i = 0; i < `SBQ_NUM_QUEUES; i++) begin
                if (wr_en) begin
                    case (window_offset(wr_addr, i))
                        sbq_pkg::BASE_LO:
                            queue_cfg[i].base_addr[31:0] <= strobed(queue_cfg[i].base_addr[31:0]);
                        sbq_pkg::BASE_HI:
                            queue_cfg[i].base_addr[63:32] <= strobed(queue_cfg[i].base_addr[63:32]);
                        sbq_pkg::CAPACITY:
                            queue_cfg[i].capacity <= strobed(queue_cfg[i].capacity);
                        sbq_pkg::ENABLE: begin
                            if (wr_strb[0]) queue_cfg[i].enable <= wr_data[0];
                        end
                        sbq_pkg::RESET: begin
                            if (wr_strb[0] && wr_data[0]) begin
                                q_reset[i]   <= 1'b1;   // tracker clears on the next edge
                                queue_cfg[i] <= cfg_default;
                            end
                        end
                        default: ;
                    endcase
                end
            end
        end
    end

    always_comb begin
        rd_data = `SBQ_UNMAPPED_VALUE;
        if (rd_en) begin
            if (rd_addr == sbq_pkg::ID_VERSION) begin
                rd_data = `SBQ_ID_VERSION;
            end else if (rd_addr == sbq_pkg::CAPABILITY) begin
                rd_data = 32'd0;
            end
            for (int i = 0; i < `SBQ_NUM_QUEUES; i++) begin
                case (window_offset(rd_addr, i))
                    sbq_pkg::BASE_LO:  rd_data = queue_cfg[i].base_addr[31:0];
                    sbq_pkg::BASE_HI:  rd_data = queue_cfg[i].base_addr[63:32];
                    sbq_pkg::CAPACITY: rd_data = queue_cfg[i].capacity;
                    sbq_pkg::ENABLE:   rd_data = {31'd0, queue_cfg[i].enable};
                    sbq_pkg::RESET:    rd_data = 32'd0;    // self clearing, never seen set
                    sbq_pkg::STATUS:   rd_data = {31'd0, status_idle[i]};
                    default: ;
                endcase
            end
        end
    end

endmodule

// File: hdl/queue_tracker.sv
`timescale 1ns/100ps
`include "sbq_cfg.svh"

module queue_tracker (
    input  logic                                       clk,
    input  logic                                       arst_n,
    input  sbq_pkg::queue_cfg_t [`SBQ_NUM_QUEUES-1:0] queue_cfg,
    input  logic [`SBQ_NUM_QUEUES-1:0]                 q_reset,
    input  logic [`SBQ_NUM_QUEUES-1:0]                 push,
    input  logic [`SBQ_NUM_QUEUES-1:0]                 pop,
    output logic [`SBQ_NUM_QUEUES-1:0]                 q_full,
    output logic [`SBQ_NUM_QUEUES-1:0]                 status_idle,
    output logic [`SBQ_NUM_QUEUES-1:0][63:0]           entry_addr
);

    logic [`SBQ_NUM_QUEUES-1:0][31:0] count;
    logic [`SBQ_NUM_QUEUES-1:0][31:0] wr_ptr;
    logic [`SBQ_NUM_QUEUES-1:0][31:0] ptr_next;
    logic [`SBQ_NUM_QUEUES-1:0]       push_ok;
    logic [`SBQ_NUM_QUEUES-1:0]       pop_ok;

    always_comb begin
        for (int i = 0; i < `SBQ_NUM_QUEUES; i++) begin
            q_full[i]      = count[i] >= queue_cfg[i].capacity;    // capacity 0 is always full
            status_idle[i] = count[i] == 32'd0;
            push_ok[i]     = push[i] && queue_cfg[i].enable && !q_full[i];
            pop_ok[i]      = pop[i] && !status_idle[i];
            ptr_next[i]    = wr_ptr[i] + 32'd1;
            if (ptr_next[i] >= queue_cfg[i].capacity) ptr_next[i] = 32'd0;
            entry_addr[i]  = queue_cfg[i].base_addr
                           + {32'd0, wr_ptr[i]} * 64'(`SBQ_ENTRY_BYTES);
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            count  <= '0;
            wr_ptr <= '0;
        end else begin
            for (int i = 0; i < `SBQ_NUM_QUEUES; i++) begin
                if (q_reset[i]) begin
                    count[i]  <= 32'd0;
                    wr_ptr[i] <= 32'd0;
                end else begin
                    // a push and a pop together leave the count alone
                    if (push_ok[i] && !pop_ok[i]) begin
                        count[i] <= count[i] + 32'd1;
                    end else if (pop_ok[i] && !push_ok[i]) begin
                        count[i] <= count[i] - 32'd1;
                    end
                    if (push_ok[i]) wr_ptr[i] <= ptr_next[i];
                end
            end
        end
    end

endmodule

// File: hdl/sbq_ctrl_top.sv
`timescale 1ns/100ps
`include "sbq_cfg.svh"

module sbq_ctrl_top (
    input  logic                             clk,
    input  logic                             arst_n,
    input  sbq_pkg::axil_aw_t                aw,
    input  logic                             aw_valid,
    output logic                             aw_ready,
    input  sbq_pkg::axil_w_t                 w,
    input  logic                             w_valid,
    output logic                             w_ready,
    output sbq_pkg::axil_b_t                 b,
    output logic                             b_valid,
    input  logic                             b_ready,
    input  sbq_pkg::axil_ar_t                ar,
    input  logic                             ar_valid,
    output logic                             ar_ready,
    output sbq_pkg::axil_r_t                 r,
    output logic                             r_valid,
    input  logic                             r_ready,
    input  logic [`SBQ_NUM_QUEUES-1:0]       push,
    input  logic [`SBQ_NUM_QUEUES-1:0]       pop,
    output logic [`SBQ_NUM_QUEUES-1:0]       q_full,
    output logic [`SBQ_NUM_QUEUES-1:0]       status_idle,
    output logic [`SBQ_NUM_QUEUES-1:0][63:0] entry_addr
);

    // AXI-Lite between the slice and the bridge
    sbq_pkg::axil_aw_t aw_q;
    sbq_pkg::axil_w_t  w_q;
    sbq_pkg::axil_b_t  b_q;
    sbq_pkg::axil_ar_t ar_q;
    sbq_pkg::axil_r_t  r_q;
    logic              aw_q_valid, aw_q_ready, w_q_valid, w_q_ready, b_q_valid, b_q_ready;
    logic              ar_q_valid, ar_q_ready, r_q_valid, r_q_ready;

    logic                                      wr_en, rd_en;
    logic [31:0]                               wr_addr, wr_data, rd_addr, rd_data;
    logic [3:0]                                wr_strb;
    sbq_pkg::queue_cfg_t [`SBQ_NUM_QUEUES-1:0] queue_cfg;
    logic [`SBQ_NUM_QUEUES-1:0]                q_reset;

    axil_register u_slice (
        .clk(clk), .arst_n(arst_n),
        .s_aw(aw), .s_aw_valid(aw_valid), .s_aw_ready(aw_ready),
        .s_w(w), .s_w_valid(w_valid), .s_w_ready(w_ready),
        .s_b(b), .s_b_valid(b_valid), .s_b_ready(b_ready),
        .s_ar(ar), .s_ar_valid(ar_valid), .s_ar_ready(ar_ready),
        .s_r(r), .s_r_valid(r_valid), .s_r_ready(r_ready),
        .m_aw(aw_q), .m_aw_valid(aw_q_valid), .m_aw_ready(aw_q_ready),
        .m_w(w_q), .m_w_valid(w_q_valid), .m_w_ready(w_q_ready),
        .m_b(b_q), .m_b_valid(b_q_valid), .m_b_ready(b_q_ready),
        .m_ar(ar_q), .m_ar_valid(ar_q_valid), .m_ar_ready(ar_q_ready),
        .m_r(r_q), .m_r_valid(r_q_valid), .m_r_ready(r_q_ready)
    );

    axil_reg_if u_bridge (
        .clk(clk), .arst_n(arst_n),
        .aw(aw_q), .aw_valid(aw_q_valid), .aw_ready(aw_q_ready),
        .w(w_q), .w_valid(w_q_valid), .w_ready(w_q_ready),
        .b(b_q), .b_valid(b_q_valid), .b_ready(b_q_ready),
        .ar(ar_q), .ar_valid(ar_q_valid), .ar_ready(ar_q_ready),
        .r(r_q), .r_valid(r_q_valid), .r_ready(r_q_ready),
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data), .wr_strb(wr_strb),
        .rd_en(rd_en), .rd_addr(rd_addr), .rd_data(rd_data)
    );

    config_registers u_regs (
        .clk(clk), .arst_n(arst_n),
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data), .wr_strb(wr_strb),
        .rd_en(rd_en), .rd_addr(rd_addr), .rd_data(rd_data),
        .status_idle(status_idle),
        .queue_cfg(queue_cfg),
        .q_reset(q_reset)
    );

    queue_tracker u_tracker (
        .clk(clk), .arst_n(arst_n),
        .queue_cfg(queue_cfg),
        .q_reset(q_reset),
        .push(push),
        .pop(pop),
        .q_full(q_full),
        .status_idle(status_idle),
        .entry_addr(entry_addr)
    );

endmodule

// File: tb/tb_clkgen.sv
`timescale 1ns/100ps

module tb_clkgen (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;    // 10 ns period
    end

    // reset held over the first 8 rising edges, released on a falling edge
    initial begin
        arst_n = 1'b0;
        repeat (8) @(negedge clk);
        arst_n = 1'b1;
    end

endmodule

// File: tb/sbq_ctrl_tb.sv
`timescale 1ns/100ps
`include "sbq_cfg.svh"

module sbq_ctrl_tb;

    localparam int nq = `SBQ_NUM_QUEUES;
    // 88 transactions of at most 14 cycles each plus reset and the push and pop pulses
    localparam int est_cycles     = 8 + 88 * 14 + 60;
    localparam int timeout_cycles = 2 * est_cycles;

    logic                   clk;
    logic                   arst_n;
    sbq_pkg::axil_aw_t      aw;
    logic                   aw_valid;
    logic                   aw_ready;
    sbq_pkg::axil_w_t       w;
    logic                   w_valid;
    logic                   w_ready;
    sbq_pkg::axil_b_t       b;
    logic                   b_valid;
    logic                   b_ready;
    sbq_pkg::axil_ar_t      ar;
    logic                   ar_valid;
    logic                   ar_ready;
    sbq_pkg::axil_r_t       r;
    logic                   r_valid;
    logic                   r_ready;
    logic [nq-1:0]          push;
    logic [nq-1:0]          pop;
    logic [nq-1:0]          q_full;
    logic [nq-1:0]          status_idle;
    logic [nq-1:0][63:0]    entry_addr;

    int          errors = 0;
    int          prop_errors = 0;
    int          checks = 0;
    int          cycles = 0;
    logic [15:0] lfsr = 16'd5;

    // shadow of the register file and the tracker
    logic [63:0] m_base [nq];
    logic [31:0] m_cap [nq];
    logic        m_en [nq];
    logic [31:0] m_count [nq];
    logic [31:0] m_ptr [nq];

    tb_clkgen clkgen (.clk(clk), .arst_n(arst_n));

    sbq_ctrl_top UUT (
        .clk(clk), .arst_n(arst_n),
        .aw(aw), .aw_valid(aw_valid), .aw_ready(aw_ready),
        .w(w), .w_valid(w_valid), .w_ready(w_ready),
        .b(b), .b_valid(b_valid), .b_ready(b_ready),
        .ar(ar), .ar_valid(ar_valid), .ar_ready(ar_ready),
        .r(r), .r_valid(r_valid), .r_ready(r_ready),
        .push(push), .pop(pop), .q_full(q_full),
        .status_idle(status_idle), .entry_addr(entry_addr)
    );

    b_hold: assert property (@(posedge clk) disable iff (!arst_n)
        b_valid && !b_ready |=> b_valid && $stable(b))
        else begin
            prop_errors++;
            $display("write response changed or vanished before it was accepted");
        end
    r_hold: assert property (@(posedge clk) disable iff (!arst_n)
        r_valid && !r_ready |=> r_valid && $stable(r))
        else begin
            prop_errors++;
            $display("read response changed or vanished before it was accepted");
        end
    b_once: assert property (@(posedge clk) disable iff (!arst_n) b_valid && b_ready |=> !b_valid)
        else begin
            prop_errors++;
            $display("write response repeated after it was accepted");
        end
    r_once: assert property (@(posedge clk) disable iff (!arst_n) r_valid && r_ready |=> !r_valid)
        else begin
            prop_errors++;
            $display("read response repeated after it was accepted");
        end
    b_okay: assert property (@(posedge clk) disable iff (!arst_n)
        b_valid |-> b.resp == sbq_pkg::resp_okay)
        else begin
            prop_errors++;
            $display("FAIL b.resp expected %h got %h", sbq_pkg::resp_okay, b.resp);
        end
    r_okay: assert property (@(posedge clk) disable iff (!arst_n)
        r_valid |-> r.resp == sbq_pkg::resp_okay)
        else begin
            prop_errors++;
            $display("FAIL r.resp expected %h got %h", sbq_pkg::resp_okay, r.resp);
        end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= timeout_cycles) begin
            $display("timeout, run stopped after %0d cycles", cycles);
            $display("Regression failed");
            $finish;
        end
    end

    // 16 bit Fibonacci LFSR with taps 16 14 13 11
    function automatic logic lfsr_step();
        logic fb;
        fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) v = {v[30:0], lfsr_step()};
        return v;
    endfunction

    function automatic logic [31:0] queue_addr(input int q, input logic [4:0] off);
        return `SBQ_QUEUE_BASE + 32'(q) * `SBQ_REG_STRIDE + {27'd0, off};
    endfunction

    task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] got);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("FAIL %s expected %h got %h", name, exp, got);
        end
    endtask

    task automatic axil_write(input logic [31:0] addr, input logic [31:0] data,
                              input logic [3:0] strb);
        logic aw_done;
        logic w_done;
        logic b_done;
        int   delay;
        int   waited;
        aw_done = 1'b0;
        w_done  = 1'b0;
        b_done  = 1'b0;
        delay   = int'(rand_bits(3));    // low delays overlap the response while high ones stall it
        waited  = 0;
        @(negedge clk);
        aw.addr  = addr;
        w.data   = data;
        w.strb   = strb;
        aw_valid = 1'b1;
        w_valid  = 1'b1;
        while (!(aw_done && w_done)) begin
            #1;
            if (aw_valid && aw_ready) aw_done = 1'b1;
            if (w_valid && w_ready) w_done = 1'b1;
            @(negedge clk);
            if (aw_done) aw_valid = 1'b0;
            if (w_done) w_valid = 1'b0;
        end
        while (!b_done) begin
            if (waited >= delay) b_ready = 1'b1;
            waited++;
            #1;
            if (b_valid && b_ready) b_done = 1'b1;
            @(negedge clk);
        end
        b_ready = 1'b0;
    endtask

    task automatic axil_read(input logic [31:0] addr, output logic [31:0] data);
        logic ar_done;
        logic r_done;
        int   delay;
        int   waited;
        ar_done = 1'b0;
        r_done  = 1'b0;
        delay   = int'(rand_bits(3));
        waited  = 0;
        data    = '0;
        @(negedge clk);
        ar.addr  = addr;
        ar_valid = 1'b1;
        while (!ar_done) begin
            #1;
            if (ar_ready) ar_done = 1'b1;
            @(negedge clk);
        end
        ar_valid = 1'b0;
        while (!r_done) begin
            if (waited >= delay) r_ready = 1'b1;
            waited++;
            #1;
            if (r_valid && r_ready) begin
                r_done = 1'b1;
                data   = r.data;
            end
            @(negedge clk);
        end
        r_ready = 1'b0;
    endtask

    task automatic read_check(input string name, input logic [31:0] addr, input logic [31:0] exp);
        logic [31:0] got;
        axil_read(addr, got);
        check_value(name, {32'd0, exp}, {32'd0, got});
    endtask

    // byte lanes with a low strobe keep their old value
    function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] data,
                                                input logic [3:0] strb);
        logic [31:0] mask;
        mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
        return (old & ~mask) | (data & mask);
    endfunction

    task automatic model_defaults(input int q);
        m_base[q]  = 64'd0;
        m_cap[q]   = `SBQ_RESET_CAPACITY;
        m_en[q]    = 1'b0;
        m_count[q] = 32'd0;
        m_ptr[q]   = 32'd0;
    endtask

    task automatic write_reg(input int q, input logic [4:0] off, input logic [31:0] data,
                             input logic [3:0] strb);
        axil_write(queue_addr(q, off), data, strb);
        case (off)
            sbq_pkg::BASE_LO:  m_base[q][31:0] = merge_bytes(m_base[q][31:0], data, strb);
            sbq_pkg::BASE_HI:  m_base[q][63:32] = merge_bytes(m_base[q][63:32], data, strb);
            sbq_pkg::CAPACITY: m_cap[q] = merge_bytes(m_cap[q], data, strb);
            sbq_pkg::ENABLE:   if (strb[0]) m_en[q] = data[0];
            sbq_pkg::RESET:    if (strb[0] && data[0]) model_defaults(q);
            default: ;
        endcase
    endtask

    task automatic check_queue_regs(input int q);
        read_check($sformatf("q%0d BASE_LO", q), queue_addr(q, sbq_pkg::BASE_LO), m_base[q][31:0]);
        read_check($sformatf("q%0d BASE_HI", q), queue_addr(q, sbq_pkg::BASE_HI), m_base[q][63:32]);
        read_check($sformatf("q%0d CAPACITY", q), queue_addr(q, sbq_pkg::CAPACITY), m_cap[q]);
        read_check($sformatf("q%0d ENABLE", q), queue_addr(q, sbq_pkg::ENABLE), {31'd0, m_en[q]});
        read_check($sformatf("q%0d STATUS", q), queue_addr(q, sbq_pkg::STATUS),
                   {31'd0, m_count[q] == 32'd0});
    endtask

    task automatic check_outputs();
        for (int q = 0; q < nq; q++) begin
            check_value($sformatf("q_full[%0d]", q), {63'd0, m_count[q] >= m_cap[q]},
                        {63'd0, q_full[q]});
            check_value($sformatf("status_idle[%0d]", q), {63'd0, m_count[q] == 32'd0},
                        {63'd0, status_idle[q]});
            check_value($sformatf("entry_addr[%0d]", q),
                        m_base[q] + {32'd0, m_ptr[q]} * 64'(`SBQ_ENTRY_BYTES), entry_addr[q]);
        end
    endtask

    // one-cycle push and pop pulse whose effect is checked after the edge that takes it
    task automatic pulse_queues(input logic [nq-1:0] push_v, input logic [nq-1:0] pop_v);
        logic push_ok;
        logic pop_ok;
        @(negedge clk);
        push = push_v;
        pop  = pop_v;
        for (int q = 0; q < nq; q++) begin
            push_ok = push_v[q] && m_en[q] && m_count[q] < m_cap[q];
            pop_ok  = pop_v[q] && m_count[q] != 32'd0;
            if (push_ok && !pop_ok) m_count[q] = m_count[q] + 32'd1;
            if (pop_ok && !push_ok) m_count[q] = m_count[q] - 32'd1;
            if (push_ok) m_ptr[q] = (m_ptr[q] + 32'd1 >= m_cap[q]) ? 32'd0 : m_ptr[q] + 32'd1;
        end
        @(negedge clk);
        push = '0;
        pop  = '0;
        #1;
        check_outputs();
    endtask

    initial begin
        logic [31:0] data;
        logic [3:0]  strb;
        logic [4:0]  off;
        int          q;
        int          sel;
        aw = '0;
        w = '0;
        ar = '0;
        aw_valid = 1'b0;
        w_valid = 1'b0;
        ar_valid = 1'b0;
        b_ready = 1'b0;
        r_ready = 1'b0;
        push = '0;
        pop = '0;
        for (int i = 0; i < nq; i++) model_defaults(i);
        @(posedge arst_n);

        // register map straight out of reset
        read_check("ID_VERSION", sbq_pkg::ID_VERSION, `SBQ_ID_VERSION);
        read_check("CAPABILITY", sbq_pkg::CAPABILITY, 32'd0);
        read_check("unmapped 0x80", 32'h80, `SBQ_UNMAPPED_VALUE);
        read_check("unmapped window", queue_addr(nq, sbq_pkg::BASE_LO), `SBQ_UNMAPPED_VALUE);
        for (int i = 0; i < nq; i++) check_queue_regs(i);
        check_outputs();

        // random strobed writes that are each read back along with the same field of the other queue
        repeat (12) begin
            q    = int'(rand_bits(1));
            sel  = int'(rand_bits(2));
            off  = (sel == 0) ? sbq_pkg::BASE_LO :
                   (sel == 1) ? sbq_pkg::BASE_HI : sbq_pkg::CAPACITY;
            data = rand_bits(32);
            strb = 4'(rand_bits(4));
            write_reg(q, off, data, strb);
            read_check($sformatf("q%0d offset %h", q, off), queue_addr(q, off),
                       off == sbq_pkg::BASE_LO ? m_base[q][31:0] :
                       off == sbq_pkg::BASE_HI ? m_base[q][63:32] : m_cap[q]);
            read_check($sformatf("q%0d offset %h", 1 - q, off), queue_addr(1 - q, off),
                       off == sbq_pkg::BASE_LO ? m_base[1 - q][31:0] :
                       off == sbq_pkg::BASE_HI ? m_base[1 - q][63:32] : m_cap[1 - q]);
        end
        for (int i = 0; i < nq; i++) check_queue_regs(i);

        // fill queue 0 past capacity and then drain it
        write_reg(0, sbq_pkg::BASE_LO, rand_bits(32), 4'hf);
        write_reg(0, sbq_pkg::BASE_HI, rand_bits(32), 4'hf);
        write_reg(0, sbq_pkg::CAPACITY, 32'd3, 4'hf);
        write_reg(0, sbq_pkg::ENABLE, 32'd1, 4'h1);
        check_outputs();
        repeat (5) pulse_queues(2'b01, 2'b00);
        check_queue_regs(0);
        pulse_queues(2'b01, 2'b01);
        pulse_queues(2'b01, 2'b01);
        repeat (4) pulse_queues(2'b00, 2'b01);
        check_queue_regs(0);

        // queue 1 ignores pushes until it is enabled
        repeat (2) pulse_queues(2'b10, 2'b00);
        write_reg(1, sbq_pkg::CAPACITY, 32'd4, 4'hf);
        write_reg(1, sbq_pkg::ENABLE, 32'd1, 4'h1);
        pulse_queues(2'b10, 2'b00);

        // queue reset restores defaults on queue 0 only
        repeat (2) pulse_queues(2'b01, 2'b00);
        write_reg(0, sbq_pkg::RESET, 32'd1, 4'h1);
        #1;
        check_outputs();
        check_queue_regs(0);
        read_check("q0 RESET", queue_addr(0, sbq_pkg::RESET), 32'd0);
        check_queue_regs(1);

        repeat (2) @(negedge clk);
        $display("checks %0d, errors %0d", checks, errors + prop_errors);
        if (errors + prop_errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: sbq_ctrl_top.f
+incdir+hdl
hdl/sbq_pkg.sv
hdl/axil_register.sv
hdl/axil_reg_if.sv
hdl/config_registers.sv
hdl/queue_tracker.sv
hdl/sbq_ctrl_top.sv
tb/tb_clkgen.sv
tb/sbq_ctrl_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log for the pass line.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module sbq_ctrl_tb -f sbq_ctrl_top.f -o sbq_sim
./obj_dir/sbq_sim | tee sim.log

if grep -qx "Regression passed" sim.log; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed"
exit 1
